// File: rtl/harness_macros.svh
/* Width, memory map, SRAM depth and debug delay constants
   shared by the harness fabric */

`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

// ----------------------------------------------------------
// Widths
// ----------------------------------------------------------
`define HARNESS_ADDR_W 32
`define HARNESS_DATA_W 32
`define HARNESS_CNT_W 16

// ----------------------------------------------------------
// Memory map
// ----------------------------------------------------------
`define HARNESS_DBG_BASE 32'h0000_0000
`define HARNESS_DBG_LEN 32'h0000_0100
`define HARNESS_ROM_BASE 32'h0001_0000
`define HARNESS_ROM_LEN 32'h0000_0040
// SRAM occupies the upper half and wraps at its depth
`define HARNESS_SRAM_BASE 32'h8000_0000

// SRAM depth in words
`define HARNESS_SRAM_WORDS 256

// Cycles after power-on reset with the halt request held back
`define HARNESS_DM_DELAY 20

`endif

// File: rtl/harness_pkg.sv
/* Shared vector types, target codes and bus FSM states */

`include "harness_macros.svh"

package harness_pkg;

  // ----------------------------------------------------------
  // Bus and debug vectors
  // ----------------------------------------------------------
  typedef logic [`HARNESS_ADDR_W-1:0]   addr_t;
  typedef logic [`HARNESS_DATA_W-1:0]   data_t;
  typedef logic [`HARNESS_DATA_W/8-1:0] strb_t;
  typedef logic [1:0]                   dmi_addr_t;
  typedef logic [`HARNESS_CNT_W-1:0]    count_t;

  // Decoded target of a bus access
  typedef logic [1:0] target_t;

  localparam target_t TGT_NONE = 2'd0;
  localparam target_t TGT_ROM  = 2'd1;
  localparam target_t TGT_SRAM = 2'd2;
  localparam target_t TGT_DBG  = 2'd3;

  // Fabric handshake FSM
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ACCESS,
    BUS_ACK,
    BUS_RELEASE
  } bus_state_e;

endpackage

// File: rtl/reset_gen.sv
/* System reset generator: power-on reset combined with ndmreset,
   asserted at once and released through a two-flop synchronizer */

`timescale 1ns/1ps

module reset_gen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // Either source pulls the system into reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Release takes two rising edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

// File: rtl/bus_fabric.sv
/* Four-phase bus slave with address decoder, one-cycle target strobe
   and response mux; unmapped and illegal accesses complete with an error */

`timescale 1ns/1ps
`include "harness_macros.svh"

module bus_fabric (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 bus_req_i,
  input  logic                 bus_we_i,
  input  harness_pkg::addr_t   bus_addr_i,
  input  harness_pkg::strb_t   bus_be_i,
  input  harness_pkg::data_t   bus_wdata_i,
  output logic                 bus_ack_o,
  output harness_pkg::data_t   bus_rdata_o,
  output logic                 bus_err_o,
  output harness_pkg::target_t mem_req_o,
  output logic                 mem_we_o,
  output harness_pkg::addr_t   mem_addr_o,
  output harness_pkg::strb_t   mem_be_o,
  output harness_pkg::data_t   mem_wdata_o,
  input  harness_pkg::data_t   rom_rdata_i,
  input  harness_pkg::data_t   sram_rdata_i,
  input  harness_pkg::data_t   dbg_rdata_i
);

  import harness_pkg::*;

  localparam addr_t DBG_BASE  = `HARNESS_DBG_BASE;
  localparam addr_t DBG_LEN   = `HARNESS_DBG_LEN;
  localparam addr_t ROM_BASE  = `HARNESS_ROM_BASE;
  localparam addr_t ROM_LEN   = `HARNESS_ROM_LEN;
  localparam addr_t SRAM_BASE = `HARNESS_SRAM_BASE;

  bus_state_e state_q;
  target_t    dec_tgt;
  target_t    tgt_q;
  logic       err_q;
  data_t      rdata_mux;
  data_t      rdata_q;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    dec_tgt = TGT_NONE;
    if ((bus_addr_i - DBG_BASE) < DBG_LEN) begin
      // Only data0 at offset 0 is mapped
      if (bus_addr_i == DBG_BASE) begin
        dec_tgt = TGT_DBG;
      end
    end else if ((bus_addr_i - ROM_BASE) < ROM_LEN) begin
      if (!bus_we_i) begin
        dec_tgt = TGT_ROM;
      end
    end else if (bus_addr_i >= SRAM_BASE) begin
      dec_tgt = TGT_SRAM;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= BUS_IDLE;
      tgt_q   <= TGT_NONE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        BUS_IDLE: begin
          if (bus_req_i) begin
            state_q <= BUS_ACCESS;
            tgt_q   <= dec_tgt;
          end
        end
        BUS_ACCESS: state_q <= BUS_ACK;
        BUS_ACK: begin
          state_q <= BUS_RELEASE;
          err_q   <= (tgt_q == TGT_NONE);
        end
        BUS_RELEASE: begin
          if (!bus_req_i) begin
            state_q <= BUS_IDLE;
            err_q   <= 1'b0;
          end
        end
        default: state_q <= BUS_IDLE;
      endcase
    end
  end

  // Request fields held for the strobe
  always_ff @(posedge clk_i) begin
    if (state_q == BUS_IDLE && bus_req_i) begin
      mem_we_o    <= bus_we_i;
      mem_addr_o  <= bus_addr_i;
      mem_be_o    <= bus_be_i;
      mem_wdata_o <= bus_wdata_i;
    end
  end

  assign mem_req_o = (state_q == BUS_ACCESS) ? tgt_q : TGT_NONE;

  // ----------------------------------------------------------
  // Response
  // ----------------------------------------------------------
  always_comb begin
    case (tgt_q)
      TGT_ROM:  rdata_mux = rom_rdata_i;
      TGT_SRAM: rdata_mux = mem_we_o ? '0 : sram_rdata_i;
      TGT_DBG:  rdata_mux = mem_we_o ? '0 : dbg_rdata_i;
      default:  rdata_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (state_q == BUS_ACK) begin
      rdata_q <= rdata_mux;
    end
  end

  assign bus_ack_o   = (state_q == BUS_RELEASE);
  assign bus_rdata_o = rdata_q;
  assign bus_err_o   = err_q;

endmodule

// File: rtl/boot_rom.sv
/* Boot ROM: fixed 16-word table with a registered read */

`timescale 1ns/1ps

module boot_rom (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  harness_pkg::addr_t addr_i,
  output harness_pkg::data_t rdata_o
);

  import harness_pkg::*;

  localparam int unsigned ROM_WORDS = 16;
  localparam data_t       ROM_TAG   = 32'hB007_0000;

  data_t      rom_table [ROM_WORDS];
  logic [3:0] rom_idx;

  // Word i holds the tag plus its index
  always_comb begin
    for (int unsigned i = 0; i < ROM_WORDS; i++) begin
      rom_table[i] = ROM_TAG + data_t'(i);
    end
  end

  assign rom_idx = addr_i[5:2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= rom_table[rom_idx];
    end
  end

endmodule

// File: rtl/sram_bank.sv
/* Byte-enabled word SRAM with registered read and
   read and write beat counters */

`timescale 1ns/1ps
`include "harness_macros.svh"

module sram_bank #(
  parameter int unsigned NUM_WORDS = `HARNESS_SRAM_WORDS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                we_i,
  input  harness_pkg::addr_t  addr_i,
  input  harness_pkg::strb_t  be_i,
  input  harness_pkg::data_t  wdata_i,
  output harness_pkg::data_t  rdata_o,
  output harness_pkg::count_t rd_count_o,
  output harness_pkg::count_t wr_count_o
);

  import harness_pkg::*;

  localparam int unsigned BYTES = `HARNESS_DATA_W / 8;
  localparam int unsigned OFF_W = $clog2(BYTES);
  localparam int unsigned IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

  data_t            mem_q [NUM_WORDS];
  logic [IDX_W-1:0] word_idx;

  // Word address wraps at the bank depth
  assign word_idx = IDX_W'((addr_i >> OFF_W) % NUM_WORDS);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BYTES; b++) begin
          if (be_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

  // Beat counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_count_o <= '0;
      wr_count_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        wr_count_o <= wr_count_o + count_t'(1);
      end else begin
        rd_count_o <= rd_count_o + count_t'(1);
      end
    end
  end

endmodule

// File: rtl/debug_unit.sv
/* Debug unit: four-phase register port, haltreq and ndmreset control,
   data0 bus window and the delayed halt-request gate */

`timescale 1ns/1ps
`include "harness_macros.svh"

module debug_unit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   dmi_req_i,
  input  logic                   dmi_we_i,
  input  harness_pkg::dmi_addr_t dmi_addr_i,
  input  harness_pkg::data_t     dmi_wdata_i,
  output logic                   dmi_ack_o,
  output harness_pkg::data_t     dmi_rdata_o,
  input  logic                   debug_enable_i,
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  harness_pkg::strb_t     bus_be_i,
  input  harness_pkg::data_t     bus_wdata_i,
  output harness_pkg::data_t     bus_rdata_o,
  output logic                   ndmreset_o,
  output logic                   debug_req_o
);

  import harness_pkg::*;

  localparam dmi_addr_t DMI_CONTROL = 2'd0;
  localparam dmi_addr_t DMI_DATA0   = 2'd1;
  localparam dmi_addr_t DMI_STATUS  = 2'd2;

  logic   dmi_access;
  logic   haltreq_q;
  data_t  data0_q;
  data_t  dmi_rdata_mux;
  count_t dly_q;

  // New access only while ack is still low
  assign dmi_access = dmi_req_i & ~dmi_ack_o;

  // ----------------------------------------------------------
  // Register port
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmi_ack_o  <= 1'b0;
      haltreq_q  <= 1'b0;
      ndmreset_o <= 1'b0;
    end else if (dmi_access) begin
      dmi_ack_o <= 1'b1;
      if (dmi_we_i && dmi_addr_i == DMI_CONTROL) begin
        haltreq_q  <= dmi_wdata_i[0];
        ndmreset_o <= dmi_wdata_i[1];
      end
    end else if (!dmi_req_i) begin
      dmi_ack_o <= 1'b0;
    end
  end

  always_comb begin
    case (dmi_addr_i)
      DMI_CONTROL: dmi_rdata_mux = data_t'({ndmreset_o, haltreq_q});
      DMI_DATA0:   dmi_rdata_mux = data0_q;
      DMI_STATUS:  dmi_rdata_mux = data_t'(debug_req_o);
      default:     dmi_rdata_mux = '0;
    endcase
  end

  // data0 is shared, the bus side wins a same-cycle write
  always_ff @(posedge clk_i) begin
    if (dmi_access) begin
      dmi_rdata_o <= dmi_rdata_mux;
    end
    if (bus_req_i && bus_we_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (bus_be_i[b]) begin
          data0_q[8*b +: 8] <= bus_wdata_i[8*b +: 8];
        end
      end
    end else if (dmi_access && dmi_we_i && dmi_addr_i == DMI_DATA0) begin
      data0_q <= dmi_wdata_i;
    end
    if (bus_req_i) begin
      bus_rdata_o <= data0_q;
    end
  end

  // ----------------------------------------------------------
  // Halt request gate
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_q <= count_t'(`HARNESS_DM_DELAY);
    end else if (dly_q != '0) begin
      dly_q <= dly_q - count_t'(1);
    end
  end

  assign debug_req_o = (dly_q == '0) & debug_enable_i & haltreq_q;

endmodule

// File: rtl/soc_harness.sv
/* Harness top: reset generator, bus fabric, boot ROM, SRAM and debug unit */

`timescale 1ns/1ps

module soc_harness (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  harness_pkg::addr_t     bus_addr_i,
  input  harness_pkg::strb_t     bus_be_i,
  input  harness_pkg::data_t     bus_wdata_i,
  output logic                   bus_ack_o,
  output harness_pkg::data_t     bus_rdata_o,
  output logic                   bus_err_o,
  input  logic                   dmi_req_i,
  input  logic                   dmi_we_i,
  input  harness_pkg::dmi_addr_t dmi_addr_i,
  input  harness_pkg::data_t     dmi_wdata_i,
  output logic                   dmi_ack_o,
  output harness_pkg::data_t     dmi_rdata_o,
  input  logic                   debug_enable_i,
  output logic                   debug_req_o,
  output harness_pkg::count_t    sram_rd_count_o,
  output harness_pkg::count_t    sram_wr_count_o
);

  import harness_pkg::*;

  logic    ndmreset;
  logic    sys_rst_n;
  target_t mem_req;
  logic    mem_we;
  addr_t   mem_addr;
  strb_t   mem_be;
  data_t   mem_wdata;
  data_t   rom_rdata;
  data_t   sram_rdata;
  data_t   dbg_rdata;

  // ----------------------------------------------------------
  // Reset and fabric
  // ----------------------------------------------------------
  reset_gen i_reset_gen (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .ndmreset_i ( ndmreset  ),
    .sys_rst_no ( sys_rst_n )
  );

  bus_fabric i_bus_fabric (
    .clk_i        ( clk_i       ),
    .rst_ni       ( sys_rst_n   ),
    .bus_req_i    ( bus_req_i   ),
    .bus_we_i     ( bus_we_i    ),
    .bus_addr_i   ( bus_addr_i  ),
    .bus_be_i     ( bus_be_i    ),
    .bus_wdata_i  ( bus_wdata_i ),
    .bus_ack_o    ( bus_ack_o   ),
    .bus_rdata_o  ( bus_rdata_o ),
    .bus_err_o    ( bus_err_o   ),
    .mem_req_o    ( mem_req     ),
    .mem_we_o     ( mem_we      ),
    .mem_addr_o   ( mem_addr    ),
    .mem_be_o     ( mem_be      ),
    .mem_wdata_o  ( mem_wdata   ),
    .rom_rdata_i  ( rom_rdata   ),
    .sram_rdata_i ( sram_rdata  ),
    .dbg_rdata_i  ( dbg_rdata   )
  );

  // ----------------------------------------------------------
  // Targets
  // ----------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i   ( clk_i               ),
    .rst_ni  ( sys_rst_n           ),
    .req_i   ( mem_req == TGT_ROM  ),
    .addr_i  ( mem_addr            ),
    .rdata_o ( rom_rdata           )
  );

  sram_bank i_sram_bank (
    .clk_i      ( clk_i               ),
    .rst_ni     ( sys_rst_n           ),
    .req_i      ( mem_req == TGT_SRAM ),
    .we_i       ( mem_we              ),
    .addr_i     ( mem_addr            ),
    .be_i       ( mem_be              ),
    .wdata_i    ( mem_wdata           ),
    .rdata_o    ( sram_rdata          ),
    .rd_count_o ( sram_rd_count_o     ),
    .wr_count_o ( sram_wr_count_o     )
  );

  // Runs on power-on reset only, so ndmreset can be released
  debug_unit i_debug_unit (
    .clk_i          ( clk_i              ),
    .rst_ni         ( rst_ni             ),
    .dmi_req_i      ( dmi_req_i          ),
    .dmi_we_i       ( dmi_we_i           ),
    .dmi_addr_i     ( dmi_addr_i         ),
    .dmi_wdata_i    ( dmi_wdata_i        ),
    .dmi_ack_o      ( dmi_ack_o          ),
    .dmi_rdata_o    ( dmi_rdata_o        ),
    .debug_enable_i ( debug_enable_i     ),
    .bus_req_i      ( mem_req == TGT_DBG ),
    .bus_we_i       ( mem_we             ),
    .bus_be_i       ( mem_be             ),
    .bus_wdata_i    ( mem_wdata          ),
    .bus_rdata_o    ( dbg_rdata          ),
    .ndmreset_o     ( ndmreset           ),
    .debug_req_o    ( debug_req_o        )
  );

endmodule

// File: verification/tb_soc_harness.sv
/* Harness fabric testbench with clock, reset, four-phase bus and
   debug port tasks, reference model, assertions and watchdog */

`timescale 1ns/1ps
`include "harness_macros.svh"

module tb_soc_harness;

  import harness_pkg::*;

  localparam int    BUS_OPS     = 18 + 32 + 40 + 32 + 10 + 8;
  localparam int    TEST_CYCLES = BUS_OPS * 8 + 300;
  localparam int    MARGIN      = 800;
  localparam int    HS_TIMEOUT  = 60;
  localparam addr_t SRAM_BASE   = `HARNESS_SRAM_BASE;
  localparam addr_t ROM_BASE    = `HARNESS_ROM_BASE;

  logic clk_i;
  logic rst_ni;
  logic bus_req_i, bus_we_i, bus_ack_o, bus_err_o;
  addr_t bus_addr_i;
  strb_t bus_be_i;
  data_t bus_wdata_i, bus_rdata_o;
  logic dmi_req_i, dmi_we_i, dmi_ack_o;
  dmi_addr_t dmi_addr_i;
  data_t dmi_wdata_i, dmi_rdata_o;
  logic debug_enable_i, debug_req_o;
  count_t sram_rd_count_o, sram_wr_count_o;

  int    errors = 0;
  int    rst_cyc = 0;
  int    seed = 28;
  data_t sram_ref [32];
  data_t data0_ref;
  int    rd_ref = 0;
  int    wr_ref = 0;

  soc_harness DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Edges since power-on reset was released
  always @(posedge clk_i) begin
    if (rst_ni) begin
      rst_cyc <= rst_cyc + 1;
    end
  end

  // ----------------------------------------------------------
  // Handshake assertions
  // ----------------------------------------------------------
  bus_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(bus_ack_o) |-> $past(bus_req_i, 1) && $past(bus_req_i, 2) && $past(bus_req_i, 3))
    else begin
      errors++;
      $display("Bus ack rose without three edges of pending request at %0t", $time);
    end
  bus_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $fell(bus_ack_o) |-> !$past(bus_req_i))
    else begin
      errors++;
      $display("Bus ack fell while request was still high at %0t", $time);
    end
  bus_ack_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $past(bus_ack_o) && $past(bus_req_i) |->
        bus_ack_o && $stable(bus_rdata_o) && $stable(bus_err_o))
    else begin
      errors++;
      $display("Bus response changed under back-pressure at %0t", $time);
    end
  dmi_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $rose(dmi_ack_o) |-> $past(dmi_req_i))
    else begin
      errors++;
      $display("Debug ack rose without a request at %0t", $time);
    end
  dmi_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $fell(dmi_ack_o) |-> !$past(dmi_req_i))
    else begin
      errors++;
      $display("Debug ack fell while request was still high at %0t", $time);
    end

  task automatic check_word(input string what, input data_t got, input data_t exp);
    assert (got === exp)
    else begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // One four-phase bus access with an optional hold after ack
  task automatic bus_access(input logic we, input addr_t addr, input strb_t be,
                            input data_t wdata, input int hold, input bit check_lat,
                            output data_t rdata, output logic err);
    int n;
    n = 0;
    @(posedge clk_i);
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_be_i    <= be;
    bus_wdata_i <= wdata;
    do begin
      @(negedge clk_i);
      n++;
    end while (!bus_ack_o && n < HS_TIMEOUT);
    if (!bus_ack_o) begin
      errors++;
      $display("Bus access to %h never received an ack", addr);
    end else if (check_lat) begin
      assert (n == 4)
      else begin
        errors++;
        $display("ERR %0t: bus ack after %0d edges, expected 3", $time, n - 1);
      end
    end
    rdata = bus_rdata_o;
    err   = bus_err_o;
    repeat (hold) begin
      @(negedge clk_i);
      check_word("held ack", data_t'(bus_ack_o), 32'd1);
    end
    @(posedge clk_i);
    bus_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (bus_ack_o && n < HS_TIMEOUT);
    if (bus_ack_o) begin
      errors++;
      $display("Bus ack stayed high after the request was dropped");
    end
  endtask

  task automatic dmi_access(input logic we, input dmi_addr_t addr, input data_t wdata,
                            output data_t rdata);
    int n;
    n = 0;
    @(posedge clk_i);
    dmi_req_i   <= 1'b1;
    dmi_we_i    <= we;
    dmi_addr_i  <= addr;
    dmi_wdata_i <= wdata;
    do begin
      @(negedge clk_i);
      n++;
    end while (!dmi_ack_o && n < HS_TIMEOUT);
    if (!dmi_ack_o) begin
      errors++;
      $display("Debug port access never received an ack");
    end else begin
      check_word("debug ack latency", data_t'(n), 32'd2);
    end
    rdata = dmi_rdata_o;
    @(posedge clk_i);
    dmi_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (dmi_ack_o && n < HS_TIMEOUT);
    if (dmi_ack_o) begin
      errors++;
      $display("Debug ack stayed high after the request was dropped");
    end
  endtask

  task automatic sram_write(input int idx, input strb_t be, input data_t wdata);
    addr_t addr;
    data_t rd;
    logic  err;
    // Random alias above the bank depth checks the wrap
    addr = SRAM_BASE | (addr_t'($random(seed) & 7) << 10) | (addr_t'(idx) << 2);
    bus_access(1'b1, addr, be, wdata, 0, 1'b1, rd, err);
    check_word("sram write err", data_t'(err), 32'd0);
    check_word("sram write rdata", rd, 32'd0);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        sram_ref[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    wr_ref++;
  endtask

  task automatic expect_err(input logic we, input addr_t addr);
    data_t rd;
    logic  err;
    bus_access(we, addr, 4'hF, 32'hDEAD_BEEF, 0, 1'b1, rd, err);
    check_word("unmapped err", data_t'(err), 32'd1);
    check_word("unmapped rdata", rd, 32'd0);
  endtask

  // ----------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------
  initial begin
    repeat (TEST_CYCLES + MARGIN) @(posedge clk_i);
    $display("Watchdog expired before the tests completed");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    data_t rd;
    logic  err;
    rst_ni = 1'b0;
    bus_req_i = 1'b0;
    bus_we_i = 1'b0;
    bus_addr_i = '0;
    bus_be_i = '0;
    bus_wdata_i = '0;
    dmi_req_i = 1'b0;
    dmi_we_i = 1'b0;
    dmi_addr_i = '0;
    dmi_wdata_i = '0;
    debug_enable_i = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Delayed halt request
    dmi_access(1'b1, 2'd0, 32'd1, rd);
    dmi_access(1'b0, 2'd0, '0, rd);
    check_word("control readback", rd, 32'd1);
    dmi_access(1'b0, 2'd2, 32'd0, rd);
    check_word("status during delay", rd, 32'd0);
    while (rst_cyc < `HARNESS_DM_DELAY + 4) begin
      @(negedge clk_i);
      check_word("debug_req vs delay", data_t'(debug_req_o),
                 data_t'(rst_cyc >= `HARNESS_DM_DELAY));
    end
    dmi_access(1'b0, 2'd2, 32'd0, rd);
    check_word("status after delay", rd, 32'd1);
    @(posedge clk_i);
    debug_enable_i <= 1'b0;
    @(negedge clk_i);
    check_word("debug_req disabled", data_t'(debug_req_o), 32'd0);
    @(posedge clk_i);
    debug_enable_i <= 1'b1;
    @(negedge clk_i);
    check_word("debug_req enabled", data_t'(debug_req_o), 32'd1);
    dmi_access(1'b1, 2'd0, 32'd0, rd);
    check_word("debug_req cleared", data_t'(debug_req_o), 32'd0);

    // Boot ROM reads with one held under back-pressure
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, ROM_BASE + addr_t'(4 * i), 4'hF, '0, (i == 3) ? 5 : 0, 1'b1, rd, err);
      check_word("rom read", rd, 32'hB007_0000 + data_t'(i));
      check_word("rom read err", data_t'(err), 32'd0);
    end
    expect_err(1'b1, ROM_BASE + 32'h8);
    bus_access(1'b0, ROM_BASE + 32'h8, 4'hF, '0, 0, 1'b1, rd, err);
    check_word("rom after write", rd, 32'hB007_0002);

    // SRAM fill, random byte writes and read back
    for (int i = 0; i < 32; i++) begin
      sram_write(i, 4'hF, data_t'($random(seed)));
    end
    for (int i = 0; i < 40; i++) begin
      sram_write($random(seed) & 31, strb_t'($random(seed)), data_t'($random(seed)));
    end
    for (int i = 0; i < 32; i++) begin
      bus_access(1'b0, SRAM_BASE + addr_t'(4 * i), 4'hF, '0, 0, 1'b1, rd, err);
      check_word("sram read", rd, sram_ref[i]);
      rd_ref++;
    end
    check_word("sram rd count", data_t'(sram_rd_count_o), data_t'(rd_ref));
    check_word("sram wr count", data_t'(sram_wr_count_o), data_t'(wr_ref));

    // Error responses
    expect_err(1'b0, 32'h0000_0004);
    expect_err(1'b1, 32'h0000_00FC);
    expect_err(1'b0, 32'h0001_0040);
    expect_err(1'b0, 32'h0002_0000);
    expect_err(1'b1, 32'h4000_0000);

    // data0 between bus and debug port
    data0_ref = 32'h1234_5678;
    bus_access(1'b1, 32'h0, 4'hF, data0_ref, 0, 1'b1, rd, err);
    bus_access(1'b1, 32'h0, 4'b0101, 32'hAABB_CCDD, 0, 1'b1, rd, err);
    data0_ref = 32'h12BB_56DD;
    dmi_access(1'b0, 2'd1, '0, rd);
    check_word("data0 via debug port", rd, data0_ref);
    dmi_access(1'b1, 2'd1, 32'hCAFE_F00D, rd);
    bus_access(1'b0, 32'h0, 4'hF, '0, 0, 1'b1, rd, err);
    check_word("data0 via bus", rd, 32'hCAFE_F00D);
    dmi_access(1'b0, 2'd3, '0, rd);
    check_word("debug index 3", rd, 32'd0);

    // ndmreset holds off a pending request
    dmi_access(1'b1, 2'd0, 32'd2, rd);
    dmi_access(1'b0, 2'd0, '0, rd);
    check_word("control with ndmreset", rd, 32'd2);
    check_word("rd count in ndmreset", data_t'(sram_rd_count_o), 32'd0);
    check_word("wr count in ndmreset", data_t'(sram_wr_count_o), 32'd0);
    fork
      begin
        bus_access(1'b0, SRAM_BASE + 32'h14, 4'hF, '0, 0, 1'b0, rd, err);
        check_word("sram after ndmreset", rd, sram_ref[5]);
      end
      begin
        repeat (10) begin
          @(negedge clk_i);
          check_word("ack during ndmreset", data_t'(bus_ack_o), 32'd0);
        end
        dmi_access(1'b1, 2'd0, 32'd0, rd);
      end
    join
    check_word("rd count after ndmreset", data_t'(sram_rd_count_o), 32'd1);

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/harness_pkg.sv
rtl/reset_gen.sv
rtl/bus_fabric.sv
rtl/boot_rom.sv
rtl/sram_bank.sv
rtl/debug_unit.sv
rtl/soc_harness.sv
verification/tb_soc_harness.sv

// File: run.sh
#!/bin/sh
# Build the harness testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_soc_harness \
  -o sim_soc_harness

sim_out=$(./obj_dir/sim_soc_harness)
echo "$sim_out"

if echo "$sim_out" | grep -q "TEST RESULT: PASS"; then
  exit 0
else
  exit 1
fi
